/* build.f */
hw/panelPkg.sv
hw/panelControl.sv
hw/digitFormatter.sv
hw/displayScanner.sv
hw/frontPanel.sv
tests/frontPanelTb.sv

/* hw/digitFormatter.sv */
`timescale 1ns/1ns
`default_nettype none

module digitFormatter (
	input wire logic c100Hz,
	input wire logic rstN,
	input wire panelPkg::switches_t sampledSwitches,
	input wire panelPkg::buttons_t sampledButtons,
	input wire panelPkg::ctrl_t ctrlValue,
	input wire panelPkg::word_t portA,
	input wire panelPkg::word_t portB,
	input wire panelPkg::word_t portC,
	input wire panelPkg::word_t portD,
	input wire panelPkg::word_t timerValue,
	input wire panelPkg::word_t cycleCount,
	input wire panelPkg::word_t traceValue,
	input wire panelPkg::word_t traceReg,
	input wire panelPkg::word_t memDataIn,
	input wire panelPkg::word_t memDataOut,
	input wire panelPkg::word_t memAddr,
	output panelPkg::word_t displayWord
);

	panelPkg::probeCode_t probeCode;
	panelPkg::word_t probeWord;
	panelPkg::word_t hexWord;
	panelPkg::word_t nextWord;
	logic [15:0] hexHalf;
	logic rawMode;

	assign probeCode = sampledSwitches[7:4];
	assign rawMode = ctrlValue[panelPkg::ctrlRawMode];

	// unused codes show zero.
	always_comb
	begin
		case (probeCode)
			panelPkg::probePortA:
				probeWord = portA;
			panelPkg::probePortB:
				probeWord = portB;
			panelPkg::probePortC:
				probeWord = portC;
			panelPkg::probePortD:
				probeWord = portD;
			panelPkg::probeTimer:
				probeWord = timerValue;
			panelPkg::probeCycles:
				probeWord = cycleCount;
			panelPkg::probeTraceValue:
				probeWord = traceValue;
			panelPkg::probeTraceReg:
				probeWord = traceReg;
			panelPkg::probeMemIn:
				probeWord = memDataIn;
			panelPkg::probeMemOut:
				probeWord = memDataOut;
			panelPkg::probeMemAddr:
				probeWord = memAddr;
			default:
				probeWord = '0;
		endcase
	end

	// the half button picks which sixteen bits fit on the four digits.
	assign hexHalf = sampledButtons[panelPkg::btnHalf] ? probeWord[31:16] : probeWord[15:0];

	for (genvar i = 0; i < 4; i++)
	begin : hexDigit
		assign hexWord[8*i +: 8] = panelPkg::hexSegments[hexHalf[4*i +: 4]];
	end

	// in raw mode the probe word already holds the segment bytes.
	assign nextWord = rawMode ? probeWord : hexWord;

	always_ff @(posedge c100Hz)
	begin
		if (!rstN)
		begin
			displayWord <= {4{panelPkg::segBlank}};
		end
		else
		begin
			displayWord <= nextWord;
		end
	end

	// hex digits never light the dp.
	hexDpOff: assert property (
		@(posedge c100Hz) disable iff (!rstN)
		!$past(rawMode)
			|-> (displayWord[31] && displayWord[23] && displayWord[15] && displayWord[7])
	);

endmodule

`default_nettype wire

/* hw/displayScanner.sv */
`timescale 1ns/1ns
`default_nettype none

module displayScanner (
	input wire logic c100Hz,
	input wire logic rstN,
	input wire panelPkg::word_t displayWord,
	output panelPkg::segByte_t segments,
	output panelPkg::anodes_t anodes
);

	panelPkg::digitIdx_t digitIdx;
	panelPkg::segByte_t digitSegments;
	panelPkg::anodes_t digitAnodes;

	// byte k of the word belongs to digit k.
	assign digitSegments = displayWord[8*digitIdx +: 8];
	assign digitAnodes = ~(panelPkg::anodes_t'(1) << digitIdx);

	// the index wraps from 3 back to 0 on its own.
	always_ff @(posedge c100Hz)
	begin
		if (!rstN)
		begin
			digitIdx <= '0;
		end
		else
		begin
			digitIdx <= digitIdx + 2'd1;
		end
	end

	// anodes and segments move together so no digit shows a neighbour's byte.
	always_ff @(posedge c100Hz)
	begin
		if (!rstN)
		begin
			anodes <= '1;
			segments <= panelPkg::segBlank;
		end
		else
		begin
			anodes <= digitAnodes;
			segments <= digitSegments;
		end
	end

	oneDigitLit: assert property (
		@(posedge c100Hz) disable iff (!rstN)
		$past(rstN) |-> $onehot(~anodes)
	);

endmodule

`default_nettype wire

/* hw/frontPanel.sv */
`timescale 1ns/1ns
`default_nettype none

module frontPanel (
	input wire logic c100Hz,
	input wire logic rstN,
	input wire panelPkg::switches_t switches,
	input wire panelPkg::buttons_t buttons,
	input wire panelPkg::word_t portA,
	input wire panelPkg::word_t portB,
	input wire panelPkg::word_t portC,
	input wire panelPkg::word_t portD,
	input wire panelPkg::word_t timerValue,
	input wire panelPkg::word_t cycleCount,
	input wire panelPkg::word_t traceValue,
	input wire panelPkg::word_t traceReg,
	input wire panelPkg::word_t memDataIn,
	input wire panelPkg::word_t memDataOut,
	input wire panelPkg::word_t memAddr,
	output wire panelPkg::segByte_t segments,
	output wire panelPkg::anodes_t anodes,
	output wire panelPkg::switches_t sampledSwitches,
	output wire panelPkg::buttons_t sampledButtons,
	output wire panelPkg::ctrl_t ctrlValue
);

	wire panelPkg::word_t displayWord;

	// the low three bits of ctrlValue carry the processor clock select.
	panelControl control (
		.c100Hz(c100Hz),
		.rstN(rstN),
		.switches(switches),
		.buttons(buttons),
		.sampledSwitches(sampledSwitches),
		.sampledButtons(sampledButtons),
		.ctrlValue(ctrlValue)
	);

	digitFormatter formatter (
		.c100Hz(c100Hz),
		.rstN(rstN),
		.sampledSwitches(sampledSwitches),
		.sampledButtons(sampledButtons),
		.ctrlValue(ctrlValue),
		.portA(portA),
		.portB(portB),
		.portC(portC),
		.portD(portD),
		.timerValue(timerValue),
		.cycleCount(cycleCount),
		.traceValue(traceValue),
		.traceReg(traceReg),
		.memDataIn(memDataIn),
		.memDataOut(memDataOut),
		.memAddr(memAddr),
		.displayWord(displayWord)
	);

	displayScanner scanner (
		.c100Hz(c100Hz),
		.rstN(rstN),
		.displayWord(displayWord),
		.segments(segments),
		.anodes(anodes)
	);

endmodule

`default_nettype wire

/* hw/panelControl.sv */
`timescale 1ns/1ns
`default_nettype none

module panelControl (
	input wire logic c100Hz,
	input wire logic rstN,
	input wire panelPkg::switches_t switches,
	input wire panelPkg::buttons_t buttons,
	output panelPkg::switches_t sampledSwitches,
	output panelPkg::buttons_t sampledButtons,
	output panelPkg::ctrl_t ctrlValue
);

	logic prevLoad;
	logic loadStrobe;
	logic loadEnable;

	// one board sample per clock is enough for these slow levels.
	always_ff @(posedge c100Hz)
	begin
		if (!rstN)
		begin
			sampledSwitches <= '0;
			sampledButtons <= '0;
		end
		else
		begin
			sampledSwitches <= switches;
			sampledButtons <= buttons;
		end
	end

	always_ff @(posedge c100Hz)
	begin
		if (!rstN)
		begin
			prevLoad <= 1'b0;
		end
		else
		begin
			prevLoad <= sampledButtons[panelPkg::btnLoad];
		end
	end

	// the strobe lasts one cycle no matter how long the button is held.
	assign loadStrobe = sampledButtons[panelPkg::btnLoad] & ~prevLoad;
	assign loadEnable = sampledButtons[panelPkg::btnEnable];

	always_ff @(posedge c100Hz)
	begin
		if (!rstN)
		begin
			ctrlValue <= '0;
		end
		else if (loadStrobe && loadEnable)
		begin
			ctrlValue <= sampledSwitches;
		end
	end

	// the register moves only after a sampled rise of load with enable held.
	ctrlLoadOnly: assert property (
		@(posedge c100Hz) disable iff (!rstN)
		(($past(rstN)) && (ctrlValue != $past(ctrlValue)))
			|-> ($past(sampledButtons[panelPkg::btnLoad]
				&& sampledButtons[panelPkg::btnEnable])
				&& !$past(sampledButtons[panelPkg::btnLoad], 2))
	);

endmodule

`default_nettype wire

/* hw/panelPkg.sv */
`default_nettype none

package panelPkg;

	typedef logic [31:0] word_t;
	typedef logic [7:0] switches_t;
	typedef logic [3:0] buttons_t;
	typedef logic [7:0] ctrl_t;

	// bit 7 is the dp, bits 6 to 0 are segments g to a, all active low.
	typedef logic [7:0] segByte_t;
	typedef logic [3:0] anodes_t;
	typedef logic [1:0] digitIdx_t;
	typedef logic [3:0] probeCode_t;

	localparam int btnLoad = 1;
	localparam int btnEnable = 2;
	localparam int btnHalf = 3;

	localparam int ctrlRawMode = 3;

	// probe select codes taken from the upper switch nibble.
	localparam probeCode_t probePortA = 4'h0;
	localparam probeCode_t probePortB = 4'h1;
	localparam probeCode_t probePortC = 4'h3;
	localparam probeCode_t probePortD = 4'h4;
	localparam probeCode_t probeTimer = 4'h7;
	localparam probeCode_t probeCycles = 4'h8;
	localparam probeCode_t probeTraceValue = 4'h9;
	localparam probeCode_t probeTraceReg = 4'hA;
	localparam probeCode_t probeMemIn = 4'hD;
	localparam probeCode_t probeMemOut = 4'hE;
	localparam probeCode_t probeMemAddr = 4'hF;

	localparam segByte_t segBlank = 8'hFF;

	// hex digit patterns 0 to F with the dp off.
	localparam segByte_t hexSegments [0:15] = '{
		8'hC0, 8'hF9, 8'hA4, 8'hB0,
		8'h99, 8'h92, 8'h82, 8'hF8,
		8'h80, 8'h90, 8'h88, 8'h83,
		8'hC6, 8'hA1, 8'h86, 8'h8E
	};

endpackage

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
	-f build.f --top-module frontPanelTb \
	-Mdir obj_dir -o frontPanelSim

if ! ./obj_dir/frontPanelSim > sim.log 2>&1
then
	cat sim.log
	echo "simulation exited with a failing status"
	exit 1
fi

cat sim.log

if grep -q "^Done: no errors$" sim.log
then
	echo "front panel simulation passed"
else
	echo "front panel simulation failed"
	exit 1
fi

/* tests/frontPanelTb.sv */
`timescale 1ns/1ns
`default_nettype none

module frontPanelTb;

	localparam int resetCycles = 16;
	localparam int randomCycles = 400;
	localparam int halfCycles = 100;
	localparam int pressCycles = 720;
	localparam int cycleLimit = 2 * (resetCycles + randomCycles + halfCycles + pressCycles);

	logic c100Hz;
	logic rstN;
	panelPkg::switches_t switches;
	panelPkg::buttons_t buttons;
	panelPkg::word_t portA, portB, portC, portD;
	panelPkg::word_t timerValue, cycleCount, traceValue, traceReg;
	panelPkg::word_t memDataIn, memDataOut, memAddr;
	panelPkg::segByte_t segments;
	panelPkg::anodes_t anodes;
	panelPkg::switches_t sampledSwitches;
	panelPkg::buttons_t sampledButtons;
	panelPkg::ctrl_t ctrlValue;

	integer seed;
	int elapsedCycles;
	logic modelValid;
	logic [7:0] expectCtrl;

	// model registers, each holding what the DUT register holds after the last edge.
	logic [7:0] mSw, mCtrl, mSeg;
	logic [3:0] mBtn, mAn;
	logic mPrevLoad;
	logic [31:0] mDisp;
	logic [1:0] mIdx;
	logic [7:0] nextSeg, nextCtrl;
	logic [3:0] nextAn;
	logic [31:0] nextDisp;

	frontPanel UUT (
		.c100Hz(c100Hz), .rstN(rstN), .switches(switches), .buttons(buttons),
		.portA(portA), .portB(portB), .portC(portC), .portD(portD),
		.timerValue(timerValue), .cycleCount(cycleCount), .traceValue(traceValue),
		.traceReg(traceReg), .memDataIn(memDataIn), .memDataOut(memDataOut),
		.memAddr(memAddr), .segments(segments), .anodes(anodes),
		.sampledSwitches(sampledSwitches), .sampledButtons(sampledButtons),
		.ctrlValue(ctrlValue)
	);

	initial
	begin
		c100Hz = 1'b0;
		forever #10 c100Hz = ~c100Hz;
	end

	task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
		begin
			$display("ERROR at %0t: %s: got %h, expected %h", $time, what, actual, expected);
			$display("Done: errors found");
			$fatal(1, "mismatch on %s", what);
		end
	endtask

	task automatic stepCycle();
		@(posedge c100Hz);
		#2;
	endtask

	function automatic logic [31:0] randomWord();
		randomWord = $random(seed);
	endfunction

	function automatic int randomBelow(input int n);
		int v;
		v = $random(seed) & 32'h7fffffff;
		return v % n;
	endfunction

	task automatic randomizeProbes();
		portA = randomWord();
		portB = randomWord();
		portC = randomWord();
		portD = randomWord();
		timerValue = randomWord();
		cycleCount = randomWord();
		traceValue = randomWord();
		traceReg = randomWord();
		memDataIn = randomWord();
		memDataOut = randomWord();
		memAddr = randomWord();
	endtask

	function automatic logic [31:0] probeFor(input logic [3:0] code);
		case (code)
			4'h0: return portA;
			4'h1: return portB;
			4'h3: return portC;
			4'h4: return portD;
			4'h7: return timerValue;
			4'h8: return cycleCount;
			4'h9: return traceValue;
			4'hA: return traceReg;
			4'hD: return memDataIn;
			4'hE: return memDataOut;
			4'hF: return memAddr;
			default: return 32'h0;
		endcase
	endfunction

	function automatic logic [31:0] modelDisplay(input logic [7:0] sw, input logic [3:0] btn,
		input logic [7:0] ctrl);
		logic [31:0] word;
		logic [15:0] half;
		logic [31:0] result;
		int i;
		word = probeFor(sw[7:4]);
		half = btn[3] ? word[31:16] : word[15:0];
		for (i = 0; i < 4; i++)
			result[8*i +: 8] = panelPkg::hexSegments[half[4*i +: 4]];
		return ctrl[3] ? word : result;
	endfunction

	task automatic checkOutputs();
		checkValue(32'(anodes), 32'(mAn), "anodes");
		checkValue(32'(segments), 32'(mSeg), "segments");
		checkValue(32'(ctrlValue), 32'(mCtrl), "ctrlValue");
		checkValue(32'(sampledSwitches), 32'(mSw), "sampledSwitches");
		checkValue(32'(sampledButtons), 32'(mBtn), "sampledButtons");
	endtask

	// inputs are stable at the falling edge, so the model steps here to the next edge.
	always @(negedge c100Hz)
	begin
		if (modelValid)
			checkOutputs();
		if (!rstN)
		begin
			mSw = 8'h00;
			mBtn = 4'h0;
			mPrevLoad = 1'b0;
			mCtrl = 8'h00;
			mDisp = {4{panelPkg::segBlank}};
			mIdx = 2'd0;
			mSeg = panelPkg::segBlank;
			mAn = 4'hF;
			modelValid = 1'b1;
		end
		else
		begin
			nextSeg = mDisp[8*mIdx +: 8];
			nextAn = ~(4'b0001 << mIdx);
			nextDisp = modelDisplay(mSw, mBtn, mCtrl);
			nextCtrl = (mBtn[1] && !mPrevLoad && mBtn[2]) ? mSw : mCtrl;
			mPrevLoad = mBtn[1];
			mSw = switches;
			mBtn = buttons;
			mDisp = nextDisp;
			mCtrl = nextCtrl;
			mSeg = nextSeg;
			mAn = nextAn;
			mIdx = mIdx + 2'd1;
		end
	end

	always @(posedge c100Hz)
	begin
		elapsedCycles = elapsedCycles + 1;
		if (elapsedCycles >= cycleLimit)
		begin
			$display("timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("Done: errors found");
			$fatal(1, "timeout");
		end
	end

	// one press of the load button, with enable held from the press until after release.
	task automatic pressLoad(input logic [7:0] sw, input logic en, input int hold,
		input logic change);
		logic [31:0] rnd;
		int i;
		switches = sw;
		buttons[panelPkg::btnLoad] = 1'b1;
		buttons[panelPkg::btnEnable] = en;
		if (en)
			expectCtrl = sw;
		for (i = 1; i < hold; i++)
		begin
			stepCycle();
			if (change)
			begin
				rnd = randomWord();
				switches = rnd[7:0];
			end
		end
		stepCycle();
		buttons[panelPkg::btnLoad] = 1'b0;
		stepCycle();
		buttons[panelPkg::btnEnable] = 1'b0;
		repeat (3) stepCycle();
		@(negedge c100Hz);
		checkValue(32'(ctrlValue), 32'(expectCtrl), "ctrlValue after press");
		stepCycle();
	endtask

	task automatic checkLitDigit(input logic [15:0] half);
		int k;
		int lit;
		lit = 0;
		for (k = 0; k < 4; k++)
			if (!anodes[k])
				lit = k;
		checkValue(32'(segments), 32'(panelPkg::hexSegments[half[4*lit +: 4]]), "hex digit");
	endtask

	initial
	begin
		logic [31:0] rnd;
		logic [3:0] scanAnodes;
		int seg;
		int k;
		seed = 32'h1cf5;
		elapsedCycles = 0;
		modelValid = 1'b0;
		expectCtrl = 8'h00;
		rstN = 1'b0;
		switches = 8'h00;
		buttons = 4'h0;
		randomizeProbes();

		repeat (3) @(posedge c100Hz);
		@(negedge c100Hz);
		checkValue(32'(anodes), 32'hF, "anodes in reset");
		checkValue(32'(segments), 32'(panelPkg::segBlank), "segments in reset");
		checkValue(32'(ctrlValue), 32'h0, "ctrlValue in reset");
		stepCycle();
		rstN = 1'b1;

		// the last edge with reset low still leaves every digit dark.
		@(negedge c100Hz);
		checkValue(32'(anodes), 32'hF, "anodes before the first scan");

		// scanning starts at digit 0 on the first edge after release.
		for (k = 0; k < 8; k++)
		begin
			@(negedge c100Hz);
			scanAnodes = ~(4'b0001 << (k % 4));
			checkValue(32'(anodes), 32'(scanAnodes), "scan order");
		end
		stepCycle();

		// every probe code comes up, and some segments reload the raw-mode bit.
		for (seg = 0; seg < randomCycles / 4; seg++)
		begin
			rnd = randomWord();
			switches = {seg[3:0], rnd[3:0]};
			buttons[panelPkg::btnHalf] = rnd[8];
			buttons[0] = rnd[9];
			if (seg % 5 == 0)
			begin
				buttons[panelPkg::btnLoad] = 1'b1;
				buttons[panelPkg::btnEnable] = 1'b1;
			end
			randomizeProbes();
			stepCycle();
			buttons[panelPkg::btnLoad] = 1'b0;
			buttons[panelPkg::btnEnable] = 1'b0;
			repeat (3) stepCycle();
		end

		// hex mode on portA while the half button toggles.
		pressLoad(8'h00, 1'b1, 1, 1'b0);
		portA = randomWord();
		for (seg = 0; seg < 10; seg++)
		begin
			buttons[panelPkg::btnHalf] = (seg % 2) == 1;
			repeat (3) stepCycle();
			for (k = 0; k < 4; k++)
			begin
				@(negedge c100Hz);
				checkLitDigit(buttons[panelPkg::btnHalf] ? portA[31:16] : portA[15:0]);
			end
			stepCycle();
		end

		for (seg = 0; seg < 60; seg++)
		begin
			rnd = randomWord();
			buttons[0] = rnd[10];
			buttons[panelPkg::btnHalf] = rnd[11];
			pressLoad(rnd[7:0], rnd[8], 1 + randomBelow(5), rnd[9]);
		end

		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire
